/* compile.f */
+incdir+source
+incdir+sim
source/mips_pkg.sv
source/hazard_if.sv
source/mips_control.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/mips_cpu.sv
sim/tb_mips_cpu.sv

/* sim/isa_model.svh */
// ##########################################################################
// Instruction-level reference model of the supported MIPS subset
// ##########################################################################
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

mips_pkg::word_t m_regs [`MIPS_NREGS];
mips_pkg::word_t m_dmem [DMEM_WORDS];
mips_pkg::word_t st_addr [$];
mips_pkg::word_t st_data [$];
int              taken_cnt;
int              not_taken_cnt;

// Runs the program one instruction at a time, no delay slot
task automatic run_model();
	mips_pkg::word_t pc;
	mips_pkg::word_t ins;
	mips_pkg::word_t a;
	mips_pkg::word_t b;
	mips_pkg::word_t simm;
	mips_pkg::word_t addr;
	mips_pkg::word_t res;
	int              wr;
	for (int i = 0; i < `MIPS_NREGS; i++) begin
		m_regs[i] = '0;
	end
	for (int i = 0; i < DMEM_WORDS; i++) begin
		m_dmem[i] = fill_word(i);
	end
	pc = `MIPS_RESET_PC;
	while (pc < 4 * PROG_LEN) begin
		ins = imem[pc[10:2]];
		a = m_regs[ins[25:21]];
		b = m_regs[ins[20:16]];
		simm = {{16{ins[15]}}, ins[15:0]};
		addr = a + simm;
		pc = pc + 32'd4;
		wr = ins[20:16];
		res = '0;
		case (ins[31:26])
			`MIPS_OP_RTYPE: begin
				wr = ins[15:11];
				case (ins[5:0])
					`MIPS_FN_ADDU: res = a + b;
					`MIPS_FN_SUBU: res = a - b;
					`MIPS_FN_AND:  res = a & b;
					`MIPS_FN_OR:   res = a | b;
					`MIPS_FN_XOR:  res = a ^ b;
					`MIPS_FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:       wr = 0;
				endcase
			end
			`MIPS_OP_ADDIU: res = a + simm;
			`MIPS_OP_ORI:   res = a | {16'h0000, ins[15:0]};
			`MIPS_OP_LUI:   res = {ins[15:0], 16'h0000};
			`MIPS_OP_LW:    res = m_dmem[addr[7:2]];
			`MIPS_OP_SW: begin
				wr = 0;
				m_dmem[addr[7:2]] = b;
				st_addr.push_back(addr);
				st_data.push_back(b);
			end
			`MIPS_OP_BEQ, `MIPS_OP_BNE: begin
				wr = 0;
				if ((a == b) != (ins[31:26] == `MIPS_OP_BNE)) begin
					pc = pc + (simm << 2);
					taken_cnt++;
				end else begin
					not_taken_cnt++;
				end
			end
			default: wr = 0;
		endcase
		// r0 stays zero
		if (wr != 0) begin
			m_regs[wr] = res;
		end
	end
endtask

`endif

/* sim/tb_mips_cpu.sv */
// ##########################################################################
// Testbench for the pipelined MIPS core: random program against ISA model
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module tb_mips_cpu;

	localparam int PROG_LEN = 60;
	localparam int IMEM_WORDS = 512;
	localparam int DMEM_WORDS = 64;
	localparam int WATCHDOG_CYCLES = (PROG_LEN + 20) * 4;

	logic            clk;
	logic            rst_n;
	mips_pkg::word_t instr_address;
	mips_pkg::word_t instr_readdata;
	mips_pkg::word_t data_address;
	logic            data_write;
	logic            data_read;
	mips_pkg::word_t data_writedata;
	mips_pkg::word_t data_readdata;
	mips_pkg::word_t register_v0;
	mips_pkg::word_t imem [IMEM_WORDS];
	mips_pkg::word_t dmem [DMEM_WORDS];
	integer          seed;
	int              errors;
	int              store_idx;
	logic            was_reset;

	function automatic mips_pkg::word_t fill_word(input int idx);
		return (mips_pkg::word_t'(idx) * 32'h9e37_79b1) ^ 32'h1357_2468;
	endfunction

	`include "isa_model.svh"

	function automatic int rand_range(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic mips_pkg::word_t enc_r(input logic [5:0] fn, input int rs,
		input int rt, input int rd);
		return {`MIPS_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic mips_pkg::word_t enc_i(input logic [5:0] op, input int rs,
		input int rt, input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	// Sources lean on the last destination to build dependency chains
	task automatic build_program();
		int         kind;
		int         dst;
		int         src;
		int         other;
		int         off;
		int         last_dst;
		logic [5:0] fn_tab [6];
		fn_tab = '{`MIPS_FN_ADDU, `MIPS_FN_SUBU, `MIPS_FN_AND, `MIPS_FN_OR,
			`MIPS_FN_XOR, `MIPS_FN_SLT};
		last_dst = 1;
		for (int i = 0; i < PROG_LEN; i++) begin
			kind = rand_range(12);
			dst = 1 + rand_range(7);
			src = rand_range(2) ? last_dst : rand_range(8);
			other = rand_range(8);
			if (kind == 11 && i < PROG_LEN - 1) begin
				off = 1 + rand_range(4);
				if (off > PROG_LEN - 1 - i) begin
					off = PROG_LEN - 1 - i;
				end
				imem[i] = enc_i(rand_range(2) ? `MIPS_OP_BEQ : `MIPS_OP_BNE, src, other, off);
			end else if (kind >= 9) begin
				imem[i] = enc_i(`MIPS_OP_SW, 0, src, rand_range(64) * 4);
			end else begin
				case (kind)
					4: imem[i] = enc_i(`MIPS_OP_ADDIU, src, dst, rand_range(65536));
					5: imem[i] = enc_i(`MIPS_OP_ORI, src, dst, rand_range(65536));
					6: imem[i] = enc_i(`MIPS_OP_LUI, 0, dst, rand_range(65536));
					7, 8: imem[i] = enc_i(`MIPS_OP_LW, 0, dst, rand_range(64) * 4);
					default: imem[i] = enc_r(fn_tab[rand_range(6)], src, other, dst);
				endcase
				last_dst = dst;
			end
		end
	endtask

	mips_cpu i_mips_cpu (
		.clk (clk),
		.rst_n (rst_n),
		.instr_address (instr_address),
		.instr_readdata (instr_readdata),
		.data_address (data_address),
		.data_write (data_write),
		.data_read (data_read),
		.data_writedata (data_writedata),
		.data_readdata (data_readdata),
		.register_v0 (register_v0)
	);

	assign instr_readdata = imem[instr_address[10:2]];
	assign data_readdata = dmem[data_address[7:2]];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Bus idle checks around reset, store checks and the data memory write
	always @(posedge clk) begin
		if (!rst_n || was_reset) begin
			if (data_write || data_read || instr_address != `MIPS_RESET_PC) begin
				errors++;
				$display("error %0t: bus not idle at reset, pc %h wr %b rd %b",
					$time, instr_address, data_write, data_read);
			end
		end
		was_reset <= !rst_n;
		if (rst_n && data_write) begin
			if (store_idx >= st_addr.size()) begin
				errors++;
				$display("Unexpected extra store at %0t to address %h", $time, data_address);
			end else if (data_address != st_addr[store_idx] ||
				data_writedata != st_data[store_idx]) begin
				errors++;
				$display("error %0t: store %0d got %h <= %h, expected %h <= %h", $time,
					store_idx, data_address, data_writedata, st_addr[store_idx],
					st_data[store_idx]);
			end
			store_idx++;
			dmem[data_address[7:2]] <= data_writedata;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: program did not drain within %0d cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		seed = 32'hc917;
		errors = 0;
		store_idx = 0;
		taken_cnt = 0;
		not_taken_cnt = 0;
		was_reset <= 1'b1;
		rst_n <= 1'b0;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] <= fill_word(i);
		end
		build_program();
		run_model();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		while (instr_address < 4 * PROG_LEN) begin
			@(posedge clk);
		end
		// Last fetched instruction still needs to reach writeback
		repeat (8) @(posedge clk);
		if (register_v0 != m_regs[`MIPS_V0]) begin
			errors++;
			$display("error %0t: v0 is %h, expected %h", $time, register_v0,
				m_regs[`MIPS_V0]);
		end
		if (store_idx != st_addr.size()) begin
			errors++;
			$display("error %0t: %0d stores seen, expected %0d", $time, store_idx,
				st_addr.size());
		end
		$display("Summary: %0d errors, %0d of %0d stores, %0d taken, %0d not taken",
			errors, store_idx, st_addr.size(), taken_cnt, not_taken_cnt);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
// ##########################################################################
// Decode stage: register file, branch compare and decode/execute register
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module decode_stage (
	input  logic              clk,
	input  logic              rst_n,
	hazard_if.stage           hz,
	input  mips_pkg::word_t   instr_d,
	input  mips_pkg::word_t   pc_plus4_d,
	input  mips_pkg::ex_mem_t ex_mem,
	input  mips_pkg::mem_wb_t mem_wb,
	input  mips_pkg::word_t   wb_result,
	output logic              take_branch,
	output mips_pkg::word_t   branch_target,
	output mips_pkg::id_ex_t  id_ex,
	output mips_pkg::word_t   register_v0
);

	mips_pkg::word_t     regs [`MIPS_NREGS];
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	logic [15:0]         imm;
	logic                wr_en;
	mips_pkg::word_t     rf_a;
	mips_pkg::word_t     rf_b;
	mips_pkg::word_t     cmp_a;
	mips_pkg::word_t     cmp_b;
	logic                eq;
	logic                zero_ext;
	mips_pkg::word_t     imm_ext;

	assign rs = instr_d[25:21];
	assign rt = instr_d[20:16];
	assign rd = instr_d[15:11];
	assign imm = instr_d[15:0];

	assign wr_en = mem_wb.reg_write && (mem_wb.write_reg != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else if (wr_en) begin
			regs[mem_wb.write_reg] <= wb_result;
		end
	end

	// Write before read
	assign rf_a = (wr_en && mem_wb.write_reg == rs) ? wb_result : regs[rs];
	assign rf_b = (wr_en && mem_wb.write_reg == rt) ? wb_result : regs[rt];
	assign register_v0 = regs[`MIPS_V0];

	// Comparator sees the memory-stage result early
	assign cmp_a = hz.fwd_cmp_a ? ex_mem.alu_result : rf_a;
	assign cmp_b = hz.fwd_cmp_b ? ex_mem.alu_result : rf_b;
	assign eq = (cmp_a == cmp_b);

	assign take_branch = hz.ctrl.branch && !hz.stall && (eq != hz.ctrl.branch_ne);
	assign branch_target = pc_plus4_d + {{14{imm[15]}}, imm, 2'b00};

	// Logical immediates are zero-extended
	assign zero_ext = hz.ctrl.alu_src_imm && (hz.ctrl.alu_op == mips_pkg::ALU_OR);
	assign imm_ext = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

	assign hz.instr_d = instr_d;
	assign hz.rs_d = rs;
	assign hz.rt_d = rt;
	assign hz.eq_d = eq;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (hz.flush_ex) begin
			id_ex <= '0;
		end else begin
			id_ex.ctrl <= hz.ctrl;
			id_ex.op_a <= rf_a;
			id_ex.op_b <= rf_b;
			id_ex.imm <= imm_ext;
			id_ex.rs <= rs;
			id_ex.rt <= rt;
			id_ex.rd <= rd;
		end
	end

	// Register zero reaches the comparator as zero, forwarded or not
	a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(rs != '0 || cmp_a == '0) && (rt != '0 || cmp_b == '0));

endmodule

`default_nettype wire

/* source/execute_stage.sv */
// ##########################################################################
// Execute stage: operand forwarding, ALU and execute/memory register
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic              clk,
	input  logic              rst_n,
	hazard_if.stage           hz,
	input  mips_pkg::id_ex_t  id_ex,
	input  mips_pkg::mem_wb_t mem_wb,
	input  mips_pkg::word_t   wb_result,
	output mips_pkg::ex_mem_t ex_mem
);

	mips_pkg::ctrl_t     c;
	mips_pkg::word_t     src_a;
	mips_pkg::word_t     fwd_b;
	mips_pkg::word_t     src_b;
	mips_pkg::word_t     alu_y;
	mips_pkg::reg_addr_t write_reg;

	function automatic mips_pkg::word_t fwd_mux(
		input mips_pkg::fwd_sel_e sel,
		input mips_pkg::word_t    reg_val,
		input mips_pkg::word_t    mem_val,
		input mips_pkg::word_t    wb_val
	);
		case (sel)
			mips_pkg::FWD_MEM: return mem_val;
			mips_pkg::FWD_WB:  return wb_val;
			default:           return reg_val;
		endcase
	endfunction

	assign c = id_ex.ctrl;

	assign src_a = fwd_mux(hz.forward_a, id_ex.op_a, ex_mem.alu_result, wb_result);
	assign fwd_b = fwd_mux(hz.forward_b, id_ex.op_b, ex_mem.alu_result, wb_result);
	assign src_b = c.alu_src_imm ? id_ex.imm : fwd_b;

	always_comb begin
		case (c.alu_op)
			mips_pkg::ALU_SUB: alu_y = src_a - src_b;
			mips_pkg::ALU_AND: alu_y = src_a & src_b;
			mips_pkg::ALU_OR:  alu_y = src_a | src_b;
			mips_pkg::ALU_XOR: alu_y = src_a ^ src_b;
			mips_pkg::ALU_SLT: alu_y = mips_pkg::word_t'($signed(src_a) < $signed(src_b));
			mips_pkg::ALU_LUI: alu_y = {src_b[15:0], 16'h0000};
			default:           alu_y = src_a + src_b;
		endcase
	end

	assign write_reg = c.dest_rd ? id_ex.rd : id_ex.rt;

	// Hazard view of execute, memory and writeback
	assign hz.rs_e = id_ex.rs;
	assign hz.rt_e = id_ex.rt;
	assign hz.write_reg_e = write_reg;
	assign hz.reg_write_e = c.reg_write;
	assign hz.mem_to_reg_e = c.mem_to_reg;
	assign hz.write_reg_m = ex_mem.write_reg;
	assign hz.reg_write_m = ex_mem.reg_write;
	assign hz.mem_to_reg_m = ex_mem.mem_to_reg;
	assign hz.write_reg_w = mem_wb.write_reg;
	assign hz.reg_write_w = mem_wb.reg_write;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.reg_write <= c.reg_write;
			ex_mem.mem_to_reg <= c.mem_to_reg;
			ex_mem.mem_write <= c.mem_write;
			ex_mem.alu_result <= alu_y;
			ex_mem.store_data <= fwd_b;
			ex_mem.write_reg <= write_reg;
		end
	end

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
// ##########################################################################
// Fetch stage: program counter, next-PC select and fetch/decode register
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module fetch_stage (
	input  logic            clk,
	input  logic            rst_n,
	hazard_if.stage         hz,
	input  logic            take_branch,
	input  mips_pkg::word_t branch_target,
	output mips_pkg::word_t instr_address,
	input  mips_pkg::word_t instr_readdata,
	output mips_pkg::word_t instr_d,
	output mips_pkg::word_t pc_plus4_d
);

	mips_pkg::word_t pc;
	mips_pkg::word_t pc_plus4;
	mips_pkg::word_t pc_next;

	assign pc_plus4 = pc + 32'd4;
	assign pc_next = take_branch ? branch_target : pc_plus4;
	assign instr_address = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `MIPS_RESET_PC;
		end else if (!hz.stall) begin
			pc <= pc_next;
		end
	end

	// Squash turns the wrongly fetched word into a no-op
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_d <= '0;
			pc_plus4_d <= '0;
		end else if (hz.squash) begin
			instr_d <= '0;
		end else if (!hz.stall) begin
			instr_d <= instr_readdata;
			pc_plus4_d <= pc_plus4;
		end
	end

endmodule

`default_nettype wire

/* source/hazard_if.sv */
// ##########################################################################
// Hazard interface between the control unit and the pipeline stages
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

interface hazard_if;

	// Stage state seen by the control unit
	mips_pkg::word_t     instr_d;
	mips_pkg::reg_addr_t rs_d;
	mips_pkg::reg_addr_t rt_d;
	logic                eq_d;
	mips_pkg::reg_addr_t rs_e;
	mips_pkg::reg_addr_t rt_e;
	mips_pkg::reg_addr_t write_reg_e;
	logic                reg_write_e;
	logic                mem_to_reg_e;
	mips_pkg::reg_addr_t write_reg_m;
	logic                reg_write_m;
	logic                mem_to_reg_m;
	mips_pkg::reg_addr_t write_reg_w;
	logic                reg_write_w;

	// Decoded controls, stalls and forwarding selects
	mips_pkg::ctrl_t     ctrl;
	logic                stall;
	logic                flush_ex;
	logic                squash;
	mips_pkg::fwd_sel_e  forward_a;
	mips_pkg::fwd_sel_e  forward_b;
	logic                fwd_cmp_a;
	logic                fwd_cmp_b;

	modport control (
		input  instr_d, rs_d, rt_d, eq_d, rs_e, rt_e, write_reg_e, reg_write_e,
		input  mem_to_reg_e, write_reg_m, reg_write_m, mem_to_reg_m,
		input  write_reg_w, reg_write_w,
		output ctrl, stall, flush_ex, squash, forward_a, forward_b, fwd_cmp_a, fwd_cmp_b
	);

	modport stage (
		output instr_d, rs_d, rt_d, eq_d, rs_e, rt_e, write_reg_e, reg_write_e,
		output mem_to_reg_e, write_reg_m, reg_write_m, mem_to_reg_m,
		output write_reg_w, reg_write_w,
		input  ctrl, stall, flush_ex, squash, forward_a, forward_b, fwd_cmp_a, fwd_cmp_b
	);

endinterface

`default_nettype wire

/* source/mem_wb_stage.sv */
// ##########################################################################
// Memory and writeback: data bus drive, memory/writeback register, result
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  mips_pkg::ex_mem_t ex_mem,
	output mips_pkg::word_t   data_address,
	output logic              data_write,
	output logic              data_read,
	output mips_pkg::word_t   data_writedata,
	input  mips_pkg::word_t   data_readdata,
	output mips_pkg::mem_wb_t mem_wb,
	output mips_pkg::word_t   wb_result
);

	assign data_address = ex_mem.alu_result;
	assign data_write = ex_mem.mem_write;
	assign data_read = ex_mem.mem_to_reg;
	assign data_writedata = ex_mem.store_data;

	// Load data is captured the same cycle the read is presented
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb.reg_write <= ex_mem.reg_write;
			mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.load_data <= data_readdata;
			mem_wb.write_reg <= ex_mem.write_reg;
		end
	end

	assign wb_result = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

	a_bus_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(data_write && data_read));

endmodule

`default_nettype wire

/* source/mips_config.svh */
// ##########################################################################
// MIPS core configuration: widths, register file and instruction encodings
// ##########################################################################
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define MIPS_XLEN       32
`define MIPS_NREGS      32
`define MIPS_RESET_PC   32'h0000_0000
`define MIPS_V0         2

// Primary opcodes
`define MIPS_OP_RTYPE   6'h00
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_BNE     6'h05
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_LUI     6'h0f
`define MIPS_OP_LW      6'h23
`define MIPS_OP_SW      6'h2b

// R-type function codes
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_XOR     6'h26
`define MIPS_FN_SLT     6'h2a

`endif

/* source/mips_control.sv */
// ##########################################################################
// MIPS control: instruction decoder, hazard detection and forwarding unit
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module mips_control (
	input logic       clk,
	input logic       rst_n,
	hazard_if.control hz
);

	logic [5:0]      op;
	logic [5:0]      funct;
	mips_pkg::ctrl_t dec;
	logic            lw_stall;
	logic            br_hit_e;
	logic            br_hit_m;
	logic            stall;

	function automatic mips_pkg::fwd_sel_e fwd_sel(
		input mips_pkg::reg_addr_t src,
		input logic                wr_m,
		input mips_pkg::reg_addr_t dst_m,
		input logic                wr_w,
		input mips_pkg::reg_addr_t dst_w
	);
		mips_pkg::fwd_sel_e sel;
		sel = mips_pkg::FWD_REG;
		if (src != '0 && wr_w && dst_w == src) begin
			sel = mips_pkg::FWD_WB;
		end
		// Memory stage holds the younger value
		if (src != '0 && wr_m && dst_m == src) begin
			sel = mips_pkg::FWD_MEM;
		end
		return sel;
	endfunction

	assign op = hz.instr_d[31:26];
	assign funct = hz.instr_d[5:0];

	// Unsupported encodings fall through as no-ops
	always_comb begin
		dec = '0;
		case (op)
			`MIPS_OP_RTYPE: begin
				dec.reg_write = 1'b1;
				dec.dest_rd = 1'b1;
				case (funct)
					`MIPS_FN_ADDU: dec.alu_op = mips_pkg::ALU_ADD;
					`MIPS_FN_SUBU: dec.alu_op = mips_pkg::ALU_SUB;
					`MIPS_FN_AND:  dec.alu_op = mips_pkg::ALU_AND;
					`MIPS_FN_OR:   dec.alu_op = mips_pkg::ALU_OR;
					`MIPS_FN_XOR:  dec.alu_op = mips_pkg::ALU_XOR;
					`MIPS_FN_SLT:  dec.alu_op = mips_pkg::ALU_SLT;
					default:       dec.reg_write = 1'b0;
				endcase
			end
			`MIPS_OP_ADDIU: begin
				dec.reg_write = 1'b1;
				dec.alu_src_imm = 1'b1;
				dec.alu_op = mips_pkg::ALU_ADD;
			end
			`MIPS_OP_ORI: begin
				dec.reg_write = 1'b1;
				dec.alu_src_imm = 1'b1;
				dec.alu_op = mips_pkg::ALU_OR;
			end
			`MIPS_OP_LUI: begin
				dec.reg_write = 1'b1;
				dec.alu_src_imm = 1'b1;
				dec.alu_op = mips_pkg::ALU_LUI;
			end
			`MIPS_OP_LW: begin
				dec.reg_write = 1'b1;
				dec.mem_to_reg = 1'b1;
				dec.alu_src_imm = 1'b1;
			end
			`MIPS_OP_SW: begin
				dec.mem_write = 1'b1;
				dec.alu_src_imm = 1'b1;
			end
			`MIPS_OP_BEQ: dec.branch = 1'b1;
			`MIPS_OP_BNE: begin
				dec.branch = 1'b1;
				dec.branch_ne = 1'b1;
			end
			default: dec = '0;
		endcase
	end

	// Load in execute feeding the instruction in decode
	assign lw_stall = hz.mem_to_reg_e && (hz.write_reg_e != '0) &&
		((hz.write_reg_e == hz.rs_d) || (hz.write_reg_e == hz.rt_d));

	// Branch operands still in flight
	assign br_hit_e = hz.reg_write_e && (hz.write_reg_e != '0) &&
		((hz.write_reg_e == hz.rs_d) || (hz.write_reg_e == hz.rt_d));
	assign br_hit_m = hz.mem_to_reg_m && (hz.write_reg_m != '0) &&
		((hz.write_reg_m == hz.rs_d) || (hz.write_reg_m == hz.rt_d));

	assign stall = lw_stall || (dec.branch && (br_hit_e || br_hit_m));

	assign hz.ctrl = dec;
	assign hz.stall = stall;
	assign hz.flush_ex = stall;
	assign hz.squash = dec.branch && !stall && (hz.eq_d != dec.branch_ne);

	assign hz.forward_a = fwd_sel(hz.rs_e, hz.reg_write_m, hz.write_reg_m,
		hz.reg_write_w, hz.write_reg_w);
	assign hz.forward_b = fwd_sel(hz.rt_e, hz.reg_write_m, hz.write_reg_m,
		hz.reg_write_w, hz.write_reg_w);

	assign hz.fwd_cmp_a = (hz.rs_d != '0) && hz.reg_write_m && (hz.write_reg_m == hz.rs_d);
	assign hz.fwd_cmp_b = (hz.rt_d != '0) && hz.reg_write_m && (hz.write_reg_m == hz.rt_d);

	// Load-use and branch stalls drain within two cycles
	a_stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
		(hz.stall && $past(hz.stall)) |=> !hz.stall);

	// Load data never reaches execute from the memory stage
	a_no_load_fwd: assert property (@(posedge clk) disable iff (!rst_n)
		!hz.mem_to_reg_m ||
		(hz.forward_a != mips_pkg::FWD_MEM && hz.forward_b != mips_pkg::FWD_MEM));

endmodule

`default_nettype wire

/* source/mips_cpu.sv */
// ##########################################################################
// Five-stage pipelined MIPS core with separate instruction and data buses
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module mips_cpu (
	input  logic            clk,
	input  logic            rst_n,
	output mips_pkg::word_t instr_address,
	input  mips_pkg::word_t instr_readdata,
	output mips_pkg::word_t data_address,
	output logic            data_write,
	output logic            data_read,
	output mips_pkg::word_t data_writedata,
	input  mips_pkg::word_t data_readdata,
	output mips_pkg::word_t register_v0
);

	logic              take_branch;
	mips_pkg::word_t   branch_target;
	mips_pkg::word_t   instr_d;
	mips_pkg::word_t   pc_plus4_d;
	mips_pkg::id_ex_t  id_ex;
	mips_pkg::ex_mem_t ex_mem;
	mips_pkg::mem_wb_t mem_wb;
	mips_pkg::word_t   wb_result;

	hazard_if hz ();

	mips_control i_mips_control (
		.clk (clk),
		.rst_n (rst_n),
		.hz (hz.control)
	);

	fetch_stage i_fetch_stage (
		.clk (clk),
		.rst_n (rst_n),
		.hz (hz.stage),
		.take_branch (take_branch),
		.branch_target (branch_target),
		.instr_address (instr_address),
		.instr_readdata (instr_readdata),
		.instr_d (instr_d),
		.pc_plus4_d (pc_plus4_d)
	);

	decode_stage i_decode_stage (
		.clk (clk),
		.rst_n (rst_n),
		.hz (hz.stage),
		.instr_d (instr_d),
		.pc_plus4_d (pc_plus4_d),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb),
		.wb_result (wb_result),
		.take_branch (take_branch),
		.branch_target (branch_target),
		.id_ex (id_ex),
		.register_v0 (register_v0)
	);

	execute_stage i_execute_stage (
		.clk (clk),
		.rst_n (rst_n),
		.hz (hz.stage),
		.id_ex (id_ex),
		.mem_wb (mem_wb),
		.wb_result (wb_result),
		.ex_mem (ex_mem)
	);

	mem_wb_stage i_mem_wb_stage (
		.clk (clk),
		.rst_n (rst_n),
		.ex_mem (ex_mem),
		.data_address (data_address),
		.data_write (data_write),
		.data_read (data_read),
		.data_writedata (data_writedata),
		.data_readdata (data_readdata),
		.mem_wb (mem_wb),
		.wb_result (wb_result)
	);

endmodule

`default_nettype wire

/* source/mips_pkg.sv */
// ##########################################################################
// MIPS core types: words, decoded controls and pipeline register payloads
// ##########################################################################
`default_nettype none
`include "mips_config.svh"

package mips_pkg;

	typedef logic [`MIPS_XLEN-1:0] word_t;
	typedef logic [$clog2(`MIPS_NREGS)-1:0] reg_addr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

	// Operand source for the execute stage
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

	typedef struct packed {
		logic    reg_write;
		logic    mem_to_reg;
		logic    mem_write;
		logic    branch;
		logic    branch_ne;
		logic    alu_src_imm;
		logic    dest_rd;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     op_a;
		word_t     op_b;
		word_t     imm;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
	} id_ex_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		logic      mem_write;
		word_t     alu_result;
		word_t     store_data;
		reg_addr_t write_reg;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		word_t     alu_result;
		word_t     load_data;
		reg_addr_t write_reg;
	} mem_wb_t;

endpackage

`default_nettype wire
